// ==== hw/exu_alu_pkg.sv ====
// widths, vector types, operation codes, multiply signedness codes and multiply FSM states
package exu_alu_pkg;

    // ====================
    // widths
    // ====================
    localparam int xlen       = 64;
    localparam int half_xlen  = 32;
    localparam int shamt_w    = 6;
    localparam int op_w       = 4;
    localparam int mul_cycles = 64;
    localparam int mul_cnt_w  = $clog2(mul_cycles + 1);

    typedef logic [xlen-1:0]    word_t;
    typedef logic [shamt_w-1:0] shamt_t;
    typedef logic [2*xlen-1:0]  dword_t;
    typedef logic [op_w-1:0]    alu_op_t;
    typedef logic [1:0]         mul_sign_t;

    // ====================
    // operation codes
    // ====================
    localparam alu_op_t op_nop    = 4'd0;
    localparam alu_op_t op_add    = 4'd1;
    localparam alu_op_t op_sub    = 4'd2;
    localparam alu_op_t op_slt    = 4'd3;
    localparam alu_op_t op_sltu   = 4'd4;
    localparam alu_op_t op_and    = 4'd5;
    localparam alu_op_t op_or     = 4'd6;
    localparam alu_op_t op_xor    = 4'd7;
    localparam alu_op_t op_sll    = 4'd8;
    localparam alu_op_t op_srl    = 4'd9;
    localparam alu_op_t op_sra    = 4'd10;
    localparam alu_op_t op_pass_b = 4'd11;
    // low half, then high halves by signedness
    localparam alu_op_t op_mul    = 4'd12;
    localparam alu_op_t op_mulh   = 4'd13;
    localparam alu_op_t op_mulhsu = 4'd14;
    localparam alu_op_t op_mulhu  = 4'd15;

    // bit 1 signs a, bit 0 signs b
    localparam mul_sign_t mul_uu = 2'd0;
    localparam mul_sign_t mul_su = 2'd2;
    localparam mul_sign_t mul_ss = 2'd3;

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_wait
    } mul_state_e;

endpackage

// ==== hw/alu_adder.sv ====
// adder/subtractor with carry, overflow, less and zero flags
`timescale 1ns/1ps

module alu_adder (
    input  exu_alu_pkg::word_t a,
    input  exu_alu_pkg::word_t b,
    input  logic               sub,
    input  logic               unsigned_cmp,
    output exu_alu_pkg::word_t sum,
    output logic               less,
    output logic               zero
);
    import exu_alu_pkg::*;

    word_t b_eff;
    logic  carry;
    logic  overflow;

    // two's complement subtract by inverting b and adding one
    assign b_eff = sub ? ~b : b;

    assign {carry, sum} = {1'b0, a} + {1'b0, b_eff} + {{xlen{1'b0}}, sub};

    // same input signs, different result sign
    assign overflow = (a[xlen-1] == b_eff[xlen-1]) && (a[xlen-1] != sum[xlen-1]);

    assign zero = (sum == '0);

    // no carry out of a - b means a borrow, so a < b unsigned
    assign less = unsigned_cmp ? (carry ^ sub) : (overflow ^ sum[xlen-1]);

endmodule

// ==== hw/alu_int_unit.sv ====
// single-cycle integer path: word cut, adder, shifter, logic ops, result select, word extension
`timescale 1ns/1ps

module alu_int_unit (
    input  exu_alu_pkg::alu_op_t op,
    input  logic                 word,
    input  exu_alu_pkg::word_t   da,
    input  exu_alu_pkg::word_t   db,
    output exu_alu_pkg::word_t   int_result,
    output exu_alu_pkg::word_t   a_cut,
    output exu_alu_pkg::word_t   b_cut,
    output logic                 int_less,
    output logic                 int_zero
);
    import exu_alu_pkg::*;

    logic              sub;
    logic              unsigned_cmp;
    word_t             add_sum;
    shamt_t            shamt;
    logic              sh_left;
    logic              sh_fill;
    word_t             sh_src;
    logic signed [xlen:0] sh_ext;
    logic [xlen:0]     sh_shifted;
    word_t             sh_right;
    word_t             sh_out;
    word_t             res_dw;

    function automatic word_t bit_rev(input word_t v);
        word_t r;
        for (int i = 0; i < xlen; i++) begin
            r[i] = v[xlen-1-i];
        end
        return r;
    endfunction

    // word mode works on zero-extended low halves
    assign a_cut = word ? {{half_xlen{1'b0}}, da[half_xlen-1:0]} : da;
    assign b_cut = word ? {{half_xlen{1'b0}}, db[half_xlen-1:0]} : db;

    assign sub          = (op == op_sub) || (op == op_slt) || (op == op_sltu);
    assign unsigned_cmp = (op == op_sltu);

    alu_adder u_alu_adder (
        .a            (a_cut),
        .b            (b_cut),
        .sub          (sub),
        .unsigned_cmp (unsigned_cmp),
        .sum          (add_sum),
        .less         (int_less),
        .zero         (int_zero)
    );

    // ====================
    // shifter
    // ====================
    // left shift reuses the right shifter on the bit-reversed operand
    assign shamt      = b_cut[shamt_w-1:0];
    assign sh_left    = (op == op_sll);
    assign sh_fill    = (op == op_sra) & a_cut[xlen-1];
    assign sh_src     = sh_left ? bit_rev(a_cut) : a_cut;
    assign sh_ext     = {sh_fill, sh_src};
    assign sh_shifted = sh_ext >>> shamt;
    assign sh_right   = sh_shifted[xlen-1:0];
    assign sh_out     = sh_left ? bit_rev(sh_right) : sh_right;

    // ====================
    // result select
    // ====================
    always_comb begin
        case (op)
            op_add, op_sub: begin
                res_dw = add_sum;
            end
            op_slt, op_sltu: begin
                res_dw = {{(xlen-1){1'b0}}, int_less};
            end
            op_and: begin
                res_dw = a_cut & b_cut;
            end
            op_or: begin
                res_dw = a_cut | b_cut;
            end
            op_xor: begin
                res_dw = a_cut ^ b_cut;
            end
            op_sll, op_srl, op_sra: begin
                res_dw = sh_out;
            end
            op_pass_b: begin
                res_dw = b_cut;
            end
            // nop and the multiply codes
            default: begin
                res_dw = '0;
            end
        endcase
    end

    assign int_result = word ? {{half_xlen{res_dw[half_xlen-1]}}, res_dw[half_xlen-1:0]}
                             : res_dw;

endmodule

// ==== hw/mul_iter.sv ====
// iterative shift-add multiplier, signed or unsigned operands, valid/ready request handshake
`timescale 1ns/1ps

module mul_iter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   mul_valid,
    input  exu_alu_pkg::mul_sign_t mul_sign,
    input  exu_alu_pkg::word_t     multiplicand,
    input  exu_alu_pkg::word_t     multiplier,
    output logic                   mul_ready,
    output logic                   mul_out_valid,
    output exu_alu_pkg::word_t     product_hi,
    output exu_alu_pkg::word_t     product_lo
);
    import exu_alu_pkg::*;

    logic                 busy;
    logic [mul_cnt_w-1:0] cnt;
    logic                 accept;
    logic                 last;
    logic                 a_neg;
    logic                 b_neg;
    word_t                a_mag;
    word_t                b_mag;
    word_t                mcand;
    dword_t               prod;
    logic                 prod_neg;
    logic [xlen:0]        part_sum;

    assign mul_ready = ~busy;
    assign accept    = mul_valid & mul_ready;
    assign last      = (cnt == mul_cnt_w'(mul_cycles));

    // operand magnitudes
    assign a_neg = mul_sign[1] & multiplicand[xlen-1];
    assign b_neg = mul_sign[0] & multiplier[xlen-1];
    assign a_mag = a_neg ? -multiplicand : multiplicand;
    assign b_mag = b_neg ? -multiplier : multiplier;

    // upper half accumulates, multiplier bits drain out of the lower half
    assign part_sum = {1'b0, prod[2*xlen-1:xlen]} + {1'b0, (prod[0] ? mcand : '0)};

    // ====================
    // control
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy          <= 1'b0;
            cnt           <= '0;
            mul_out_valid <= 1'b0;
        end else begin
            mul_out_valid <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                if (last) begin
                    busy          <= 1'b0;
                    mul_out_valid <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // ====================
    // datapath
    // ====================
    always_ff @(posedge clk) begin
        if (accept) begin
            mcand    <= a_mag;
            prod     <= {{xlen{1'b0}}, b_mag};
            prod_neg <= a_neg ^ b_neg;
        end else if (busy) begin
            if (last) begin
                prod <= prod_neg ? -prod : prod;
            end else begin
                prod <= {part_sum, prod[xlen-1:1]};
            end
        end
    end

    assign product_hi = prod[2*xlen-1:xlen];
    assign product_lo = prod[xlen-1:0];

endmodule

// ==== hw/mul_ctrl.sv ====
// multiply control FSM, operand capture, result and flag registers, ready level
`timescale 1ns/1ps

module mul_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  exu_alu_pkg::alu_op_t   op,
    input  logic                   word,
    input  exu_alu_pkg::word_t     a_cut,
    input  exu_alu_pkg::word_t     b_cut,
    input  exu_alu_pkg::word_t     int_result,
    input  logic                   int_less,
    input  logic                   int_zero,
    input  logic                   mul_ready,
    input  logic                   mul_out_valid,
    input  exu_alu_pkg::word_t     product_hi,
    input  exu_alu_pkg::word_t     product_lo,
    output exu_alu_pkg::word_t     result,
    output logic                   less,
    output logic                   zero,
    output logic                   alu_ready,
    output logic                   mul_valid,
    output exu_alu_pkg::mul_sign_t mul_sign,
    output exu_alu_pkg::word_t     multiplicand,
    output exu_alu_pkg::word_t     multiplier
);
    import exu_alu_pkg::*;

    mul_state_e state;
    mul_state_e next_state;
    logic       is_mul_op;
    logic       accept_mul;
    logic       accept_int;
    logic       done;
    logic       is_hi;
    logic       is_word;
    word_t      prod_sel;
    word_t      prod_res;

    assign is_mul_op = (op == op_mul) || (op == op_mulh) ||
                       (op == op_mulhsu) || (op == op_mulhu);

    assign alu_ready  = (state == st_idle);
    assign mul_valid  = (state == st_req);
    assign accept_mul = alu_ready & is_mul_op;
    assign accept_int = alu_ready & ~is_mul_op;
    assign done       = (state == st_wait) & mul_out_valid;

    // ====================
    // FSM
    // ====================
    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (accept_mul) begin
                    next_state = st_req;
                end
            end
            st_req: begin
                // request transfers once the multiplier is idle
                if (mul_valid & mul_ready) begin
                    next_state = st_wait;
                end
            end
            st_wait: begin
                if (mul_out_valid) begin
                    next_state = st_idle;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // operands stay stable until the transfer edge
    always_ff @(posedge clk) begin
        if (accept_mul) begin
            multiplicand <= a_cut;
            multiplier   <= b_cut;
            is_hi        <= (op != op_mul);
            is_word      <= word;
            case (op)
                op_mulhsu: begin
                    mul_sign <= mul_su;
                end
                op_mulhu: begin
                    mul_sign <= mul_uu;
                end
                default: begin
                    mul_sign <= mul_ss;
                end
            endcase
        end
    end

    // ====================
    // result
    // ====================
    assign prod_sel = is_hi ? product_hi : product_lo;
    assign prod_res = is_word ? {{half_xlen{prod_sel[half_xlen-1]}}, prod_sel[half_xlen-1:0]}
                              : prod_sel;

    // flags keep their value across a multiply
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
            less   <= 1'b0;
            zero   <= 1'b0;
        end else if (accept_int) begin
            result <= int_result;
            less   <= int_less;
            zero   <= int_zero;
        end else if (done) begin
            result <= prod_res;
        end
    end

endmodule

// ==== hw/exu_alu.sv ====
// execute unit top level: integer unit, multiply controller and iterative multiplier
`timescale 1ns/1ps

module exu_alu (
    input  logic                 clk,
    input  logic                 rst_n,
    input  exu_alu_pkg::alu_op_t op,
    input  logic                 word,
    input  exu_alu_pkg::word_t   da,
    input  exu_alu_pkg::word_t   db,
    output exu_alu_pkg::word_t   result,
    output logic                 less,
    output logic                 zero,
    output logic                 alu_ready
);
    import exu_alu_pkg::*;

    word_t     int_result;
    word_t     a_cut;
    word_t     b_cut;
    logic      int_less;
    logic      int_zero;
    logic      mul_valid;
    logic      mul_ready;
    logic      mul_out_valid;
    mul_sign_t mul_sign;
    word_t     multiplicand;
    word_t     multiplier;
    word_t     product_hi;
    word_t     product_lo;

    alu_int_unit u_alu_int_unit (
        .op         (op),
        .word       (word),
        .da         (da),
        .db         (db),
        .int_result (int_result),
        .a_cut      (a_cut),
        .b_cut      (b_cut),
        .int_less   (int_less),
        .int_zero   (int_zero)
    );

    mul_ctrl u_mul_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .op            (op),
        .word          (word),
        .a_cut         (a_cut),
        .b_cut         (b_cut),
        .int_result    (int_result),
        .int_less      (int_less),
        .int_zero      (int_zero),
        .mul_ready     (mul_ready),
        .mul_out_valid (mul_out_valid),
        .product_hi    (product_hi),
        .product_lo    (product_lo),
        .result        (result),
        .less          (less),
        .zero          (zero),
        .alu_ready     (alu_ready),
        .mul_valid     (mul_valid),
        .mul_sign      (mul_sign),
        .multiplicand  (multiplicand),
        .multiplier    (multiplier)
    );

    mul_iter u_mul_iter (
        .clk           (clk),
        .rst_n         (rst_n),
        .mul_valid     (mul_valid),
        .mul_sign      (mul_sign),
        .multiplicand  (multiplicand),
        .multiplier    (multiplier),
        .mul_ready     (mul_ready),
        .mul_out_valid (mul_out_valid),
        .product_hi    (product_hi),
        .product_lo    (product_lo)
    );

endmodule

// ==== verif/exu_alu_tb.sv ====
// execute unit testbench with clock, reset, LFSR stimulus, reference model, checks and watchdog
`timescale 1ns/1ps

module exu_alu_tb;
    import exu_alu_pkg::*;

    localparam int clk_period  = 40;
    localparam int drive_delay = 2;
    localparam int n_int       = 400;
    localparam int n_shift     = 100;
    localparam int n_mul       = 60;
    localparam int n_mix       = 3;
    localparam int n_ops       = n_int + n_shift + n_mul + n_mix;
    localparam int watchdog_ns = n_ops * (mul_cycles + 10) * clk_period;
    localparam logic [31:0] lfsr_taps = 32'hA300_0000;

    logic    clk;
    logic    rst_n;
    alu_op_t op;
    logic    word;
    word_t   da;
    word_t   db;
    word_t   result;
    logic    less;
    logic    zero;
    logic    alu_ready;

    logic [31:0] lfsr_state = 32'd15;
    word_t       last_result;
    logic        exp_less;
    logic        exp_zero;

    exu_alu u_exu_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .op        (op),
        .word      (word),
        .da        (da),
        .db        (db),
        .result    (result),
        .less      (less),
        .zero      (zero),
        .alu_ready (alu_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ====================
    // helpers
    // ====================
    // one LFSR step per bit taken
    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[xlen-2:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ lfsr_taps) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    function automatic word_t pick_operand();
        logic [2:0] sel;
        sel = 3'(rand_bits(3));
        case (sel)
            3'd0: return '0;
            3'd1: return '1;
            3'd2: return {1'b1, {(xlen-1){1'b0}}};
            default: return rand_bits(xlen);
        endcase
    endfunction

    function automatic word_t sext_word(input word_t v);
        return {{half_xlen{v[half_xlen-1]}}, v[half_xlen-1:0]};
    endfunction

    task automatic fail_stop();
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            fail_stop();
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
            fail_stop();
        end
    endtask

    // ====================
    // reference model
    // ====================
    task automatic model_int(input alu_op_t o, input logic w, input word_t x, input word_t y,
                             output word_t res, output logic lt, output logic zr);
        word_t                a;
        word_t                b;
        word_t                sum;
        shamt_t               sh;
        logic                 is_sub;
        logic signed [xlen:0] wide;
        a      = w ? word_t'(x[half_xlen-1:0]) : x;
        b      = w ? word_t'(y[half_xlen-1:0]) : y;
        sh     = shamt_t'(b);
        is_sub = (o == op_sub) || (o == op_slt) || (o == op_sltu);
        sum    = is_sub ? a - b : a + b;
        zr     = (sum == '0);
        // without subtract, less is the sign of the exact sum
        wide   = $signed({a[xlen-1], a}) + $signed({b[xlen-1], b});
        if (o == op_sltu) begin
            lt = (a < b);
        end else if (is_sub) begin
            lt = ($signed(a) < $signed(b));
        end else begin
            lt = wide[xlen];
        end
        case (o)
            op_add, op_sub: res = sum;
            op_slt, op_sltu: res = {{(xlen-1){1'b0}}, lt};
            op_and: res = a & b;
            op_or: res = a | b;
            op_xor: res = a ^ b;
            op_sll: res = a << sh;
            op_srl: res = a >> sh;
            op_sra: res = $signed(a) >>> sh;
            op_pass_b: res = b;
            default: res = '0;
        endcase
        if (w) begin
            res = sext_word(res);
        end
    endtask

    function automatic word_t model_mul(input alu_op_t o, input logic w, input word_t x,
                                        input word_t y);
        word_t  a;
        word_t  b;
        dword_t ax;
        dword_t bx;
        dword_t p;
        word_t  half;
        a    = w ? word_t'(x[half_xlen-1:0]) : x;
        b    = w ? word_t'(y[half_xlen-1:0]) : y;
        ax   = (o == op_mulhu) ? {{xlen{1'b0}}, a} : {{xlen{a[xlen-1]}}, a};
        bx   = (o == op_mulhu || o == op_mulhsu) ? {{xlen{1'b0}}, b} : {{xlen{b[xlen-1]}}, b};
        p    = ax * bx;
        half = (o == op_mul) ? p[xlen-1:0] : p[2*xlen-1:xlen];
        return w ? sext_word(half) : half;
    endfunction

    // ====================
    // one operation
    // ====================
    // called 2 ns after a rising edge with alu_ready high
    task automatic run_op(input alu_op_t o, input logic w, input word_t x, input word_t y);
        word_t exp_res;
        logic  lt;
        logic  zr;
        op   = o;
        word = w;
        da   = x;
        db   = y;
        @(posedge clk);
        #(drive_delay);
        if (o < op_mul) begin
            model_int(o, w, x, y, exp_res, lt, zr);
            check_word("result", result, exp_res);
            check_bit("less", less, lt);
            check_bit("zero", zero, zr);
            check_bit("alu_ready after single-cycle op", alu_ready, 1'b1);
            exp_less = lt;
            exp_zero = zr;
        end else begin
            exp_res = model_mul(o, w, x, y);
            check_bit("alu_ready after multiply accept", alu_ready, 1'b0);
            while (alu_ready !== 1'b1) begin
                check_word("result held during multiply", result, last_result);
                check_bit("less held during multiply", less, exp_less);
                check_bit("zero held during multiply", zero, exp_zero);
                // DUT must ignore these while busy
                op   = alu_op_t'(rand_bits(4) % 12);
                word = 1'(rand_bits(1));
                da   = rand_bits(xlen);
                db   = rand_bits(xlen);
                @(posedge clk);
                #(drive_delay);
            end
            check_word("product", result, exp_res);
            check_bit("less after multiply", less, exp_less);
            check_bit("zero after multiply", zero, exp_zero);
        end
        last_result = exp_res;
    endtask

    initial begin
        #(watchdog_ns);
        $display("watchdog expired: the DUT never became ready again");
        fail_stop();
    end

    // ====================
    // test sequence
    // ====================
    initial begin
        alu_op_t o;
        logic    w;
        word_t   x;
        word_t   y;
        rst_n = 1'b0;
        op    = op_nop;
        word  = 1'b0;
        da    = '0;
        db    = '0;
        repeat (4) @(posedge clk);
        #(drive_delay);
        rst_n = 1'b1;
        check_bit("alu_ready after reset", alu_ready, 1'b1);
        check_word("result after reset", result, '0);
        check_bit("less after reset", less, 1'b0);
        check_bit("zero after reset", zero, 1'b0);
        last_result = '0;
        exp_less    = 1'b0;
        exp_zero    = 1'b0;

        for (int i = 0; i < n_int; i++) begin
            o = alu_op_t'(rand_bits(4) % 12);
            w = 1'(rand_bits(1));
            x = pick_operand();
            y = pick_operand();
            run_op(o, w, x, y);
        end

        for (int i = 0; i < n_shift; i++) begin
            o = alu_op_t'(op_sll + rand_bits(2) % 3);
            w = 1'(rand_bits(1));
            x = pick_operand();
            y = rand_bits(xlen);
            run_op(o, w, x, y);
        end

        for (int i = 0; i < n_mul; i++) begin
            o = alu_op_t'(op_mul + rand_bits(2));
            w = (o == op_mul) ? 1'(rand_bits(1)) : 1'b0;
            x = pick_operand();
            y = pick_operand();
            run_op(o, w, x, y);
        end

        // multiply, add, multiply back to back
        x = pick_operand();
        y = pick_operand();
        run_op(op_mulh, 1'b0, x, y);
        x = pick_operand();
        y = pick_operand();
        run_op(op_add, 1'b0, x, y);
        x = pick_operand();
        y = pick_operand();
        run_op(op_mulhsu, 1'b0, x, y);

        $display("sim passed");
        $finish;
    end

endmodule

// ==== exu_alu.f ====
hw/exu_alu_pkg.sv
hw/alu_adder.sv
hw/alu_int_unit.sv
hw/mul_iter.sv
hw/mul_ctrl.sv
hw/exu_alu.sv
verif/exu_alu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module exu_alu_tb \
    -f exu_alu.f \
    -o exu_alu_tb_sim

./obj_dir/exu_alu_tb_sim
